// File: include/risc_defs.svh
// core widths and depths; RISC_MEM_WORDS must equal 2**RISC_AW and RISC_XLEN is RISC_DLEN + 2
`ifndef RISC_DEFS_SVH
`define RISC_DEFS_SVH

// register width
// data word plus carry in bit 32 and overflow in bit 33
`define RISC_XLEN       34

// data and memory word
`define RISC_DLEN       32

// shared memory address and depth
`define RISC_AW         8
`define RISC_MEM_WORDS  256

// register file
`define RISC_RAW        5
`define RISC_NREGS      32

`endif

// File: verilog/risc_pkg.sv
// core types; opcodes overlap between classes so they are constants and not an enum
`default_nettype none
`include "risc_defs.svh"

package risc_pkg;

    // instruction type field, bits 31:30
    typedef enum logic [1:0] {
        cls_movement = 2'b00,
        cls_flowctrl = 2'b01,
        cls_logic    = 2'b10,
        cls_arith    = 2'b11
    } ins_class_t;

    // opcode field, bits 29:27, read together with the class
    typedef logic [2:0] opc_t;
    localparam opc_t load   = 3'b000;
    localparam opc_t loadi  = 3'b001;
    localparam opc_t store  = 3'b010;
    localparam opc_t mov    = 3'b100;
    localparam opc_t nop    = 3'b111;
    localparam opc_t or_op  = 3'b000;
    localparam opc_t inv_op = 3'b001;
    localparam opc_t and_op = 3'b010;
    localparam opc_t add_op = 3'b000;
    localparam opc_t sub_op = 3'b001;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_or,
        alu_and,
        alu_inv
    } alu_op_t;

    // execute operand source for RB and RC
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // which peer owns the memory this cycle
    typedef enum logic [1:0] {
        own_none,
        own_host,
        own_data,
        own_fetch
    } mem_owner_t;

    typedef struct packed {
        logic [`RISC_RAW-1:0]  ra;
        logic [`RISC_RAW-1:0]  rb;
        logic [`RISC_RAW-1:0]  rc;
        alu_op_t               alu_op;
        logic                  writes_reg;
        logic                  is_load;
        logic                  is_store;
        logic                  use_imm;
        logic                  use_imm_rc;
        // loadi only, alu A operand forced to zero
        logic                  zero_a;
        // already sign extended from imm or imm_rc
        logic [`RISC_DLEN-1:0] imm;
    } decoded_t;

    // all zero is a bubble that writes nothing
    localparam decoded_t dec_nop = '0;
    localparam logic [`RISC_DLEN-1:0] nop_word = {2'b00, 3'b111, 27'd0};

endpackage

`default_nettype wire

// File: verilog/mem_port_if.sv
// one client per instance; gnt is combinational and rdata follows a granted read by one cycle
`default_nettype none
`include "risc_defs.svh"

interface mem_port_if;

    // client holds req until it sees gnt in the same cycle
    logic                   req;
    logic                   we;
    logic [`RISC_AW-1:0]    addr;
    logic [`RISC_DLEN-1:0]  wdata;

    // back from the arbiter
    logic                   gnt;
    logic [`RISC_DLEN-1:0]  rdata;

    modport client (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// File: verilog/register_file.sv
// combinational reads with write-through; a same-cycle write shows on the read ports
`default_nettype none
`include "risc_defs.svh"

module register_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [`RISC_RAW-1:0]        i_ra_addr,
    input  wire                         i_ra_we,
    input  wire  [`RISC_XLEN-1:0]       i_ra_data,
    input  wire  [`RISC_RAW-1:0]        i_rb_addr,
    input  wire  [`RISC_RAW-1:0]        i_rc_addr,
    output logic [`RISC_XLEN-1:0]       o_rb_data,
    output logic [`RISC_XLEN-1:0]       o_rc_data
);

    logic [`RISC_XLEN-1:0] regs [`RISC_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RISC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_ra_we) begin
            regs[i_ra_addr] <= i_ra_data;
        end
    end

    // bypass covers decode reading what writeback writes now
    assign o_rb_data = (i_ra_we && i_ra_addr == i_rb_addr) ? i_ra_data : regs[i_rb_addr];
    assign o_rc_data = (i_ra_we && i_ra_addr == i_rc_addr) ? i_ra_data : regs[i_rc_addr];

endmodule

`default_nettype wire

// File: verilog/hazard_unit.sv
// purely combinational; a load in memory is never a forward source, the stall covers it
`default_nettype none
`include "risc_defs.svh"

module hazard_unit
    import risc_pkg::*;
(
    input  wire decoded_t               i_dec,
    input  wire decoded_t               i_exe,
    input  wire decoded_t               i_mem,
    input  wire decoded_t               i_wb,
    output fwd_sel_t                    o_fwd_b_sel,
    output fwd_sel_t                    o_fwd_c_sel,
    output logic                        o_stall
);

    // memory checked last so it overrides writeback
    function automatic fwd_sel_t pick(
        input logic [`RISC_RAW-1:0] src,
        input decoded_t             mem_ins,
        input decoded_t             wb_ins
    );
        fwd_sel_t sel;
        sel = fwd_none;
        if (wb_ins.writes_reg && wb_ins.ra == src) begin
            sel = fwd_wb;
        end
        if (mem_ins.writes_reg && !mem_ins.is_load && mem_ins.ra == src) begin
            sel = fwd_mem;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_b_sel = pick(i_exe.rb, i_mem, i_wb);
        o_fwd_c_sel = pick(i_exe.rc, i_mem, i_wb);
    end

    // load result not ready until writeback
    assign o_stall = i_exe.is_load && (i_exe.ra == i_dec.rb || i_exe.ra == i_dec.rc);

endmodule

`default_nettype wire

// File: verilog/shared_memory.sv
// host owns the memory whenever i_run is low; the core must not request then
`default_nettype none
`include "risc_defs.svh"

module shared_memory
    import risc_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_run,
    input  wire                         i_host_we,
    input  wire  [`RISC_AW-1:0]         i_host_addr,
    input  wire  [`RISC_DLEN-1:0]       i_host_wdata,
    output logic [`RISC_DLEN-1:0]       o_host_rdata,
    mem_port_if.arbiter                 fetch_port,
    mem_port_if.arbiter                 data_port
);

    logic [`RISC_DLEN-1:0]  mem [`RISC_MEM_WORDS];
    mem_owner_t             owner;
    mem_owner_t             owner_q;
    logic [`RISC_AW-1:0]    addr;
    logic                   we;
    logic [`RISC_DLEN-1:0]  wdata;
    logic [`RISC_DLEN-1:0]  rd_q;

    //////////////////////////////////////////////////////////////////////
    // fixed priority: host, data, fetch
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        owner = own_none;
        if (!i_run) begin
            owner = own_host;
        end else if (data_port.req) begin
            owner = own_data;
        end else if (fetch_port.req) begin
            owner = own_fetch;
        end
    end

    assign data_port.gnt  = (owner == own_data);
    assign fetch_port.gnt = (owner == own_fetch);

    // single access path into the array
    always_comb begin
        case (owner)
            own_host: begin
                addr  = i_host_addr;
                we    = i_host_we;
                wdata = i_host_wdata;
            end
            own_data: begin
                addr  = data_port.addr;
                we    = data_port.we;
                wdata = data_port.wdata;
            end
            own_fetch: begin
                addr  = fetch_port.addr;
                we    = fetch_port.we;
                wdata = fetch_port.wdata;
            end
            default: begin
                addr  = '0;
                we    = 1'b0;
                wdata = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // array and registered read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RISC_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            owner_q <= own_none;
        end else begin
            if (we) begin
                mem[addr] <= wdata;
            end
            owner_q <= owner;
        end
    end

    // read before write on the same address
    always_ff @(posedge clk) begin
        rd_q <= mem[addr];
    end

    // word goes back only to last cycle's owner
    assign o_host_rdata     = (owner_q == own_host)  ? rd_q : '0;
    assign data_port.rdata  = (owner_q == own_data)  ? rd_q : '0;
    assign fetch_port.rdata = (owner_q == own_fetch) ? rd_q : '0;

    // the core stays off the memory while the host owns it
    assert property (@(posedge clk) disable iff (!rst_n)
        !i_run |-> !(fetch_port.req || data_port.req));

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
// presents a NOP whenever no new word arrived; pc restarts at 0 while i_run is low
`default_nettype none
`include "risc_defs.svh"

module fetch_unit
    import risc_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_run,
    input  wire                         i_stall,
    mem_port_if.client                  fetch_port,
    output logic [`RISC_DLEN-1:0]       o_instr
);

    logic [`RISC_AW-1:0]    pc_q;
    logic                   got_q;
    logic                   hold_vld_q;
    logic [`RISC_DLEN-1:0]  hold_q;

    // no request during a stall so pc stays put
    assign fetch_port.req   = i_run && !i_stall;
    assign fetch_port.we    = 1'b0;
    assign fetch_port.addr  = pc_q;
    assign fetch_port.wdata = '0;

    // held word first, then a fresh read, else bubble
    always_comb begin
        if (hold_vld_q) begin
            o_instr = hold_q;
        end else if (got_q) begin
            o_instr = fetch_port.rdata;
        end else begin
            o_instr = nop_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !i_run) begin
            pc_q       <= '0;
            got_q      <= 1'b0;
            hold_vld_q <= 1'b0;
        end else begin
            if (fetch_port.req && fetch_port.gnt) begin
                pc_q <= pc_q + 1'b1;
            end
            got_q      <= fetch_port.req && fetch_port.gnt;
            hold_vld_q <= i_stall;
        end
    end

    // decode word replayed the cycle after a stall
    always_ff @(posedge clk) begin
        if (i_stall) begin
            hold_q <= o_instr;
        end
    end

    // no grant reaches a stalled fetch
    assert property (@(posedge clk) disable iff (!rst_n || !i_run)
        i_stall |-> !fetch_port.gnt);

endmodule

`default_nettype wire

// File: verilog/pipeline_datapath.sv
// decode works on i_instr directly; all stages flush to NOP while i_run is low
`default_nettype none
`include "risc_defs.svh"

module pipeline_datapath
    import risc_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_run,
    input  wire  [`RISC_DLEN-1:0]       i_instr,
    mem_port_if.client                  data_port,
    output logic                        o_stall,
    output logic                        o_wb_valid,
    output logic [`RISC_RAW-1:0]        o_wb_addr,
    output logic [`RISC_XLEN-1:0]       o_wb_data
);

    decoded_t               dec;
    decoded_t               exe_q;
    decoded_t               mem_q;
    decoded_t               wb_q;
    logic [`RISC_DLEN-1:0]  imm_ext;
    logic [`RISC_DLEN-1:0]  imm_rc_ext;
    logic [`RISC_XLEN-1:0]  rb_data;
    logic [`RISC_XLEN-1:0]  rc_data;
    logic [`RISC_XLEN-1:0]  exe_b;
    logic [`RISC_XLEN-1:0]  exe_c;
    logic [`RISC_XLEN-1:0]  b_fwd;
    logic [`RISC_XLEN-1:0]  c_fwd;
    logic [`RISC_XLEN-1:0]  opa;
    logic [`RISC_XLEN-1:0]  opb;
    logic [`RISC_DLEN:0]    sum;
    logic [`RISC_XLEN-1:0]  alu_out;
    logic [`RISC_XLEN-1:0]  mem_alu;
    logic [`RISC_DLEN-1:0]  mem_wdata;
    logic [`RISC_XLEN-1:0]  wb_alu;
    logic [`RISC_XLEN-1:0]  wb_data;
    fwd_sel_t               fwd_b_sel;
    fwd_sel_t               fwd_c_sel;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////
    assign imm_ext    = {{20{i_instr[26]}}, i_instr[26:15]};
    // imm and RC fields together
    assign imm_rc_ext = {{15{i_instr[26]}}, i_instr[26:10]};

    always_comb begin
        dec    = dec_nop;
        dec.ra = i_instr[4:0];
        dec.rb = i_instr[9:5];
        dec.rc = i_instr[14:10];
        case (ins_class_t'(i_instr[31:30]))
            cls_movement: begin
                case (i_instr[29:27])
                    load: begin
                        dec.writes_reg = 1'b1;
                        dec.is_load    = 1'b1;
                        dec.use_imm_rc = 1'b1;
                        dec.imm        = imm_rc_ext;
                    end
                    loadi: begin
                        dec.writes_reg = 1'b1;
                        dec.use_imm_rc = 1'b1;
                        dec.zero_a     = 1'b1;
                        dec.imm        = imm_rc_ext;
                    end
                    store: begin
                        dec.is_store = 1'b1;
                        dec.use_imm  = 1'b1;
                        dec.imm      = imm_ext;
                    end
                    // RB plus a zero immediate
                    mov: begin
                        dec.writes_reg = 1'b1;
                        dec.use_imm    = 1'b1;
                    end
                    default: dec.writes_reg = 1'b0;
                endcase
            end
            cls_logic: begin
                dec.writes_reg = 1'b1;
                case (i_instr[29:27])
                    or_op:   dec.alu_op = alu_or;
                    inv_op:  dec.alu_op = alu_inv;
                    and_op:  dec.alu_op = alu_and;
                    default: dec.writes_reg = 1'b0;
                endcase
            end
            cls_arith: begin
                dec.writes_reg = 1'b1;
                case (i_instr[29:27])
                    add_op:  dec.alu_op = alu_add;
                    sub_op:  dec.alu_op = alu_sub;
                    default: dec.writes_reg = 1'b0;
                endcase
            end
            // flow control not supported, runs as a bubble
            default: dec.writes_reg = 1'b0;
        endcase
    end

    register_file u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ra_addr  (wb_q.ra),
        .i_ra_we    (wb_q.writes_reg),
        .i_ra_data  (wb_data),
        .i_rb_addr  (dec.rb),
        .i_rc_addr  (dec.rc),
        .o_rb_data  (rb_data),
        .o_rc_data  (rc_data)
    );

    hazard_unit u_hazard (
        .i_dec       (dec),
        .i_exe       (exe_q),
        .i_mem       (mem_q),
        .i_wb        (wb_q),
        .o_fwd_b_sel (fwd_b_sel),
        .o_fwd_c_sel (fwd_c_sel),
        .o_stall     (o_stall)
    );

    //////////////////////////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (fwd_b_sel)
            fwd_mem: b_fwd = mem_alu;
            fwd_wb:  b_fwd = wb_data;
            default: b_fwd = exe_b;
        endcase
        case (fwd_c_sel)
            fwd_mem: c_fwd = mem_alu;
            fwd_wb:  c_fwd = wb_data;
            default: c_fwd = exe_c;
        endcase
        opa = exe_q.zero_a ? '0 : b_fwd;
        // immediates carry zero flags
        opb = (exe_q.use_imm || exe_q.use_imm_rc) ? {2'b00, exe_q.imm} : c_fwd;
    end

    // arith sets carry and signed overflow, logic clears both
    always_comb begin
        sum     = '0;
        alu_out = '0;
        case (exe_q.alu_op)
            alu_add: begin
                sum     = {1'b0, opa[`RISC_DLEN-1:0]} + {1'b0, opb[`RISC_DLEN-1:0]};
                alu_out = {(opa[31] == opb[31]) && (sum[31] != opa[31]), sum};
            end
            alu_sub: begin
                sum     = {1'b0, opa[`RISC_DLEN-1:0]} - {1'b0, opb[`RISC_DLEN-1:0]};
                alu_out = {(opa[31] != opb[31]) && (sum[31] != opa[31]), sum};
            end
            alu_or:  alu_out = {2'b00, opa[`RISC_DLEN-1:0] | opb[`RISC_DLEN-1:0]};
            alu_and: alu_out = {2'b00, opa[`RISC_DLEN-1:0] & opb[`RISC_DLEN-1:0]};
            alu_inv: alu_out = {2'b00, ~opa[`RISC_DLEN-1:0]};
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stage registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || !i_run) begin
            exe_q <= dec_nop;
            mem_q <= dec_nop;
            wb_q  <= dec_nop;
        end else begin
            // bubble into execute on a load-use stall
            exe_q <= o_stall ? dec_nop : dec;
            mem_q <= exe_q;
            wb_q  <= mem_q;
        end
    end

    always_ff @(posedge clk) begin
        exe_b     <= rb_data;
        exe_c     <= rc_data;
        mem_alu   <= alu_out;
        mem_wdata <= c_fwd[`RISC_DLEN-1:0];
        wb_alu    <= mem_alu;
    end

    //////////////////////////////////////////////////////////////////////
    // memory and writeback
    //////////////////////////////////////////////////////////////////////
    assign data_port.req   = i_run && (mem_q.is_load || mem_q.is_store);
    assign data_port.we    = mem_q.is_store;
    assign data_port.addr  = mem_alu[`RISC_AW-1:0];
    assign data_port.wdata = mem_wdata;

    // load word lands one cycle after its grant
    assign wb_data    = wb_q.is_load ? {2'b00, data_port.rdata} : wb_alu;
    assign o_wb_valid = wb_q.writes_reg;
    assign o_wb_addr  = wb_q.ra;
    assign o_wb_data  = wb_data;

    // data stage outranks fetch whenever the core runs
    assert property (@(posedge clk) disable iff (!rst_n)
        data_port.req |-> data_port.gnt);

    // a load feeding decode must raise the stall
    assert property (@(posedge clk) disable iff (!rst_n || !i_run)
        !(exe_q.is_load && (exe_q.ra == dec.rb || exe_q.ra == dec.rc) && !o_stall));

endmodule

`default_nettype wire

// File: verilog/risc_top.sv
// host port works only with i_run low; first writeback latency after i_run varies with arbitration
`default_nettype none

module risc_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         i_run,
    input  wire         i_host_we,
    input  wire  [7:0]  i_host_addr,
    input  wire  [31:0] i_host_wdata,
    output logic [31:0] o_host_rdata,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_addr,
    output logic [33:0] o_wb_data
);

    logic        stall;
    logic [31:0] instr;

    // fetch and data stage share the one memory
    mem_port_if fetch_port ();
    mem_port_if data_port ();

    shared_memory u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_run        (i_run),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_rdata (o_host_rdata),
        .fetch_port   (fetch_port.arbiter),
        .data_port    (data_port.arbiter)
    );

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_run      (i_run),
        .i_stall    (stall),
        .fetch_port (fetch_port.client),
        .o_instr    (instr)
    );

    pipeline_datapath u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_run      (i_run),
        .i_instr    (instr),
        .data_port  (data_port.client),
        .o_stall    (stall),
        .o_wb_valid (o_wb_valid),
        .o_wb_addr  (o_wb_addr),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// 8 ns free-running clock; rst_n held low for the first 5 rising edges, released on a falling edge
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous reset, so count rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_risc_top.sv
// every row reloads all 256 words; data sits at 0xE8..0xF5, well past the longest program
`default_nettype none

module tb_risc_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_rows       = 14;
    localparam int run_limit    = 400;
    localparam int quiet_cycles = 24;
    localparam int op_add = 0;
    localparam int op_sub = 1;
    localparam int op_or  = 2;
    localparam int op_and = 3;
    localparam int op_inv = 4;
    localparam int op_mov = 5;
    // r6 base, low 8 bits give 0xF0
    localparam logic [16:0] base_val = 17'h001F0;

    logic        clk;
    logic        rst_n;
    logic        i_run;
    logic        i_host_we;
    logic [7:0]  i_host_addr;
    logic [31:0] i_host_wdata;
    logic [31:0] o_host_rdata;
    logic        o_wb_valid;
    logic [4:0]  o_wb_addr;
    logic [33:0] o_wb_data;

    // operation and nop gap between dependent instructions, per row
    int tab_op  [n_rows] = '{op_add, op_sub, op_or, op_and, op_inv, op_mov, op_add,
                             op_sub, op_or, op_and, op_inv, op_mov, op_add, op_sub};
    int tab_gap [n_rows] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1, 2, 2};

    // memory image to load, and memory and registers as the program leaves them
    logic [31:0] image  [256];
    logic [31:0] mem_m  [256];
    logic [33:0] regs_m [32];
    logic [4:0]  exp_addr [$];
    logic [33:0] exp_data [$];
    logic [31:0] rng;
    logic        hung;
    int          pc;
    int          errors;
    int          checks;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    risc_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_run        (i_run),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_rdata (o_host_rdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb_addr    (o_wb_addr),
        .o_wb_data    (o_wb_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // type and opcode, 12-bit immediate, RC, RB, RA
    function automatic logic [31:0] encode(input logic [4:0] cls_opc, input logic [11:0] imm,
                                           input logic [4:0] rc, input logic [4:0] rb,
                                           input logic [4:0] ra);
        return {cls_opc, imm, rc, rb, ra};
    endfunction

    function automatic logic [4:0] op_code(input int op);
        case (op)
            op_add:  return 5'b11_000;
            op_sub:  return 5'b11_001;
            op_or:   return 5'b10_000;
            op_and:  return 5'b10_010;
            op_inv:  return 5'b10_001;
            default: return 5'b00_100;
        endcase
    endfunction

    // data bits only; carry from unsigned 33-bit, overflow from signed 33-bit result
    function automatic logic [33:0] alu_model(input int op, input logic [33:0] x,
                                              input logic [33:0] y);
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] u;
        logic [32:0] s;
        a = x[31:0];
        b = y[31:0];
        u = '0;
        s = '0;
        case (op)
            op_add: begin
                u = {1'b0, a} + {1'b0, b};
                s = {a[31], a} + {b[31], b};
                return {s[32] ^ s[31], u};
            end
            op_sub: begin
                u = {1'b0, a} - {1'b0, b};
                s = {a[31], a} - {b[31], b};
                return {s[32] ^ s[31], u};
            end
            op_or:   return {2'b00, a | b};
            op_and:  return {2'b00, a & b};
            op_inv:  return {2'b00, ~a};
            default: return {2'b00, a};
        endcase
    endfunction

    task automatic put_word(input logic [31:0] w);
        image[pc] = w;
        mem_m[pc] = w;
        pc++;
    endtask

    task automatic expect_write(input logic [4:0] ra, input logic [33:0] v);
        regs_m[ra] = v;
        exp_addr.push_back(ra);
        exp_data.push_back(v);
    endtask

    task automatic alu_instr(input int op, input logic [4:0] ra, input logic [4:0] rb,
                             input logic [4:0] rc);
        put_word(encode(op_code(op), 12'd0, rc, rb, ra));
        expect_write(ra, alu_model(op, regs_m[rb], regs_m[rc]));
    endtask

    // 17-bit value spans immediate and RC fields
    task automatic loadi_instr(input logic [4:0] ra, input logic [16:0] v);
        put_word({5'b00_001, v, 5'd0, ra});
        expect_write(ra, {2'b00, {15{v[16]}}, v});
    endtask

    task automatic load_instr(input logic [4:0] ra, input logic [4:0] rb, input logic [16:0] off);
        logic [31:0] ea;
        ea = regs_m[rb][31:0] + {{15{off[16]}}, off};
        put_word({5'b00_000, off, rb, ra});
        expect_write(ra, {2'b00, mem_m[ea[7:0]]});
    endtask

    task automatic store_instr(input logic [4:0] rc, input logic [4:0] rb, input logic [11:0] off);
        logic [31:0] ea;
        ea = regs_m[rb][31:0] + {{20{off[11]}}, off};
        put_word(encode(5'b00_010, off, rc, rb, 5'd0));
        mem_m[ea[7:0]] = regs_m[rc][31:0];
    endtask

    task automatic nop_fill(input int n);
        for (int i = 0; i < n; i++) begin
            put_word(encode(5'b00_111, 12'd0, 5'd0, 5'd0, 5'd0));
        end
    endtask

    task automatic build_program(input int row);
        int          op;
        int          gap;
        logic [16:0] a;
        logic [16:0] b;
        logic [16:0] c;
        logic [31:0] w0;
        op  = tab_op[row];
        gap = tab_gap[row];
        rng = xorshift32(rng);
        a   = rng[16:0];
        rng = xorshift32(rng);
        b   = rng[16:0];
        rng = xorshift32(rng);
        c   = rng[16:0];
        // nop fill with the address in the immediate field
        for (int i = 0; i < 256; i++) begin
            image[i] = {5'b00_111, 4'd0, i[7:0], 15'd0};
        end
        // wide operands, picked so add and sub always overflow
        rng = xorshift32(rng);
        w0  = {rng[31], ~rng[31], rng[29:0]};
        image[8'hF4] = w0;
        rng = xorshift32(rng);
        image[8'hF5] = (op == op_sub) ? {~w0[31:30], rng[29:0]} : {w0[31:30], rng[29:0]};
        mem_m = image;
        exp_addr.delete();
        exp_data.delete();
        pc = 0;
        loadi_instr(5'd6, base_val);
        loadi_instr(5'd1, a);
        nop_fill(gap);
        loadi_instr(5'd2, b);
        nop_fill(gap);
        // dependent chain, forwarded from memory or writeback by gap
        alu_instr(op, 5'd3, 5'd1, 5'd2);
        nop_fill(gap);
        alu_instr(op, 5'd4, 5'd3, 5'd2);
        nop_fill(gap);
        alu_instr(op, 5'd5, 5'd4, 5'd3);
        store_instr(5'd5, 5'd6, 12'd0);
        // negative offset, wraps to 0xE8
        store_instr(5'd4, 5'd6, 12'hFF8);
        loadi_instr(5'd9, c);
        store_instr(5'd9, 5'd6, 12'd3);
        load_instr(5'd7, 5'd6, 17'd3);
        // load-use stall
        alu_instr(op_add, 5'd8, 5'd7, 5'd1);
        store_instr(5'd8, 5'd6, 12'd2);
        load_instr(5'd10, 5'd6, 17'd4);
        load_instr(5'd11, 5'd6, 17'd5);
        alu_instr(op, 5'd12, 5'd10, 5'd11);
        // flags of r5 must come back clear
        load_instr(5'd13, 5'd6, 17'd0);
        store_instr(5'd12, 5'd6, 12'd1);
        nop_fill(8);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            hung = 1'b1;
            $display("reset was never released");
        end
    endtask

    // host owns memory while i_run is low, one word per cycle
    task automatic load_image();
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            checks++;
            if (o_wb_valid !== 1'b0) begin
                errors++;
                $display("[FAIL] t=%0t o_wb_valid got %b expected 0", $time, o_wb_valid);
            end
            i_host_we    = 1'b1;
            i_host_addr  = i[7:0];
            i_host_wdata = image[i];
        end
        @(negedge clk);
        i_host_we = 1'b0;
    endtask

    task automatic collect_writes(input int row);
        int got;
        int waited;
        got    = 0;
        waited = 0;
        while (got < exp_addr.size() && waited < run_limit) begin
            @(negedge clk);
            waited++;
            if (o_wb_valid) begin
                checks++;
                if (o_wb_addr !== exp_addr[got]) begin
                    errors++;
                    $display("[FAIL] t=%0t o_wb_addr got %0d expected %0d (row %0d write %0d)",
                             $time, o_wb_addr, exp_addr[got], row, got);
                end
                if (o_wb_data !== exp_data[got]) begin
                    errors++;
                    $display("[FAIL] t=%0t o_wb_data got %h expected %h (row %0d write %0d)",
                             $time, o_wb_data, exp_data[got], row, got);
                end
                got++;
            end
        end
        if (got < exp_addr.size()) begin
            errors++;
            hung = 1'b1;
            $display("row %0d: only %0d of %0d register writes arrived before the timeout",
                     row, got, exp_addr.size());
        end else begin
            // trailing nops, nothing more may retire
            for (int i = 0; i < quiet_cycles; i++) begin
                @(negedge clk);
                if (o_wb_valid) begin
                    errors++;
                    $display("row %0d: unexpected extra register write to r%0d", row, o_wb_addr);
                end
            end
        end
    endtask

    // caller is at a falling edge with i_run just dropped
    task automatic read_back(input int row);
        i_host_addr = 8'd0;
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            checks++;
            if (o_host_rdata !== mem_m[i]) begin
                errors++;
                $display("[FAIL] t=%0t o_host_rdata[%0d] got %h expected %h (row %0d)",
                         $time, i, o_host_rdata, mem_m[i], row);
            end
            i_host_addr = 8'(i + 1);
        end
    endtask

    initial begin
        i_run        = 1'b0;
        i_host_we    = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        errors       = 0;
        checks       = 0;
        hung         = 1'b0;
        pc           = 0;
        rng          = 32'd36059;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        wait_reset();
        for (int row = 0; row < n_rows && !hung; row++) begin
            build_program(row);
            load_image();
            i_run = 1'b1;
            collect_writes(row);
            if (!hung) begin
                @(negedge clk);
                i_run = 1'b0;
                read_back(row);
            end
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/risc_pkg.sv
verilog/mem_port_if.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/shared_memory.sv
verilog/fetch_unit.sv
verilog/pipeline_datapath.sv
verilog/risc_top.sv
testbench/tb_clk_gen.sv
testbench/tb_risc_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_risc_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Verification passed

VFLAGS    ?= --timing --assert --top-module $(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
